// File: chipset.f
soc_pkg.sv
ps2_receiver.sv
kbd_controller.sv
system_ram.sv
seg_display.sv
chipset.sv
chipset_tb.sv

// File: chipset.sv
`timescale 1ns/1ps
`default_nettype none

module chipset
    import soc_pkg::*;
    (
        input  wire logic                  cpu_clk_i,
        input  wire logic                  reset_async_i,
        input  wire logic                  ps2_clk_async_i,
        input  wire logic                  ps2_data_async_i,
        input  wire logic [15:0]           switch_async_i,

        // Data bus from the CPU side
        input  wire logic [WORD_W-1:0]     bus_addr_i,
        input  wire logic [WORD_W-1:0]     bus_write_data_i,
        input  wire logic [WORD_BYTES-1:0] bus_write_mask_i,
        output logic [WORD_W-1:0]          bus_read_data_o,

        output logic                       kbd_irq_o,
        output logic [7:0]                 dsp_anode_o,
        output logic [7:0]                 dsp_cathode_o
    );

logic                    cpu_reset_r;
logic [RESET_CYCLES-1:0] cpu_reset_chain_r;

// Reset input is sampled, then stretched through the chain
always_ff @(posedge cpu_clk_i) begin
    if (reset_async_i) begin
        {cpu_reset_r, cpu_reset_chain_r} <= '1;
    end else begin
        {cpu_reset_r, cpu_reset_chain_r} <= {cpu_reset_chain_r, 1'b0};
    end
end

// Two-flop synchronizer on the switch bank
logic [15:0] switch_meta_r;
logic [15:0] switch_r;

always_ff @(posedge cpu_clk_i) begin
    switch_meta_r <= switch_async_i;
    switch_r      <= switch_meta_r;
end

bus_addr_u bus_addr_w;
bus_addr_u read_addr_r;

logic [WORD_BYTES-1:0]  ram_write_mask_w;
logic [WORD_BYTES-1:0]  dsp_write_mask_w;
logic                   kbd_read_enable_w;

logic [WORD_W-1:0]      ram_read_data_w;
logic [WORD_W-1:0]      dsp_read_data_w;
logic [KBD_EVENT_W-1:0] kbd_event_w;
logic                   kbd_valid_w;

assign bus_addr_w.word = bus_addr_i;

// Write decode, only RAM and the display accept writes
assign ram_write_mask_w  = (bus_addr_w.field.region == REGION_RAM) ? bus_write_mask_i : '0;
assign dsp_write_mask_w  = (bus_addr_w.word == ADDR_DISPLAY) ? bus_write_mask_i : '0;
assign kbd_read_enable_w = (bus_addr_w.word == ADDR_KBD);

kbd_controller i_kbd (
    .cpu_clk_i        (cpu_clk_i),
    .reset_i          (cpu_reset_r),
    .ps2_clk_async_i  (ps2_clk_async_i),
    .ps2_data_async_i (ps2_data_async_i),
    .read_enable_i    (kbd_read_enable_w),
    .read_data_o      (kbd_event_w),
    .read_valid_o     (kbd_valid_w),
    .irq_o            (kbd_irq_o)
);

system_ram i_ram (
    .cpu_clk_i    (cpu_clk_i),
    .addr_i       (bus_addr_w),
    .write_data_i (bus_write_data_i),
    .write_mask_i (ram_write_mask_w),
    .read_data_o  (ram_read_data_w)
);

seg_display i_disp (
    .cpu_clk_i     (cpu_clk_i),
    .reset_i       (cpu_reset_r),
    .write_data_i  (bus_write_data_i),
    .write_mask_i  (dsp_write_mask_w),
    .read_data_o   (dsp_read_data_w),
    .dsp_anode_o   (dsp_anode_o),
    .dsp_cathode_o (dsp_cathode_o)
);

// Read data comes back one cycle after the address
always_ff @(posedge cpu_clk_i) begin
    if (cpu_reset_r) begin
        read_addr_r.word <= '0;
    end else begin
        read_addr_r <= bus_addr_w;
    end
end

always_comb begin
    bus_read_data_o = '0;
    case (read_addr_r.field.region)
        REGION_RAM:               bus_read_data_o = ram_read_data_w;
        // No BIOS or video RAM behind these regions
        REGION_BIOS, REGION_VRAM: bus_read_data_o = '0;
        default: begin
            if (read_addr_r.word == ADDR_DISPLAY) begin
                bus_read_data_o = dsp_read_data_w;
            end else if (read_addr_r.word == ADDR_SWITCH) begin
                bus_read_data_o = {16'h0000, switch_r};
            end else if (read_addr_r.word == ADDR_KBD) begin
                bus_read_data_o = {15'd0, kbd_valid_w, 7'd0, kbd_event_w};
            end
        end
    endcase
end

a_single_write_target: assert property (@(posedge cpu_clk_i) disable iff (cpu_reset_r)
    $onehot0({|ram_write_mask_w, |dsp_write_mask_w}));

endmodule

`default_nettype wire

// File: chipset_tb.sv
`timescale 1ns/1ps
`default_nettype none

module chipset_tb
    import soc_pkg::*;
    ();

localparam logic [WORD_W-1:0] IDLE_ADDR    = 32'h0000_0000;
localparam int                PS2_HALF_BIT = 10;
localparam int                DIGIT_LIMIT  = 9 * SEG_SCAN_DIV;

logic              cpu_clk;
logic              reset_async;
logic              ps2_clk;
logic              ps2_data;
logic [15:0]       switch_in;
logic [WORD_W-1:0] bus_addr;
logic [WORD_W-1:0] bus_wdata;
logic [3:0]        bus_mask;
logic [WORD_W-1:0] bus_rdata;
logic              kbd_irq;
logic [7:0]        dsp_anode;
logic [7:0]        dsp_cathode;

integer            seed;
int                check_count;
int                error_count;
int                test_start;
logic [WORD_W-1:0] ram_shadow [RAM_WORDS];

chipset i_dut (
    .cpu_clk_i        (cpu_clk),
    .reset_async_i    (reset_async),
    .ps2_clk_async_i  (ps2_clk),
    .ps2_data_async_i (ps2_data),
    .switch_async_i   (switch_in),
    .bus_addr_i       (bus_addr),
    .bus_write_data_i (bus_wdata),
    .bus_write_mask_i (bus_mask),
    .bus_read_data_o  (bus_rdata),
    .kbd_irq_o        (kbd_irq),
    .dsp_anode_o      (dsp_anode),
    .dsp_cathode_o    (dsp_cathode)
);

initial begin
    cpu_clk = 1'b0;
    forever begin
        #10 cpu_clk = ~cpu_clk;
    end
end

// Expected keyboard word as the bus returns it
function automatic logic [31:0] kbd_word(input logic valid, input logic release_flag,
                                         input logic [7:0] code);
    return {15'd0, valid, 7'd0, release_flag, code};
endfunction

// Segments lit for a hex digit with segment a in bit 0
function automatic logic [7:0] seg_pattern(input logic [3:0] nibble);
    logic [6:0] lit;
    case (nibble)
        4'h0:    lit = 7'h3F;
        4'h1:    lit = 7'h06;
        4'h2:    lit = 7'h5B;
        4'h3:    lit = 7'h4F;
        4'h4:    lit = 7'h66;
        4'h5:    lit = 7'h6D;
        4'h6:    lit = 7'h7D;
        4'h7:    lit = 7'h07;
        4'h8:    lit = 7'h7F;
        4'h9:    lit = 7'h6F;
        4'hA:    lit = 7'h77;
        4'hB:    lit = 7'h7C;
        4'hC:    lit = 7'h39;
        4'hD:    lit = 7'h5E;
        4'hE:    lit = 7'h79;
        default: lit = 7'h71;
    endcase
    // Active-low cathodes with the decimal point dark
    return {1'b1, ~lit};
endfunction

function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [3:0]  mask);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
            result[b*8 +: 8] = new_word[b*8 +: 8];
        end
    end
    return result;
endfunction

task automatic check(input string name, input logic [31:0] expected,
                     input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic end_test(input string name);
    if (error_count == test_start) begin
        $display("test %s: ok", name);
    end else begin
        $display("test %s: %0d errors", name, error_count - test_start);
    end
    test_start = error_count;
endtask

// One bus cycle with read data sampled after the following edge
task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] mask, output logic [31:0] rdata);
    @(posedge cpu_clk);
    #2;
    bus_addr  = addr;
    bus_wdata = wdata;
    bus_mask  = mask;
    @(posedge cpu_clk);
    #2;
    bus_addr  = IDLE_ADDR;
    bus_mask  = 4'h0;
    rdata     = bus_rdata;
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] mask);
    logic [31:0] unused;
    bus_access(addr, wdata, mask, unused);
endtask

task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_access(addr, 32'h0, 4'h0, rdata);
endtask

task automatic idle_cycles(input int count);
    repeat (count) @(posedge cpu_clk);
    #2;
endtask

// Keyboard side of PS/2 with data changing while the clock is high
task automatic send_ps2_frame(input logic [7:0] code, input logic bad_parity);
    logic [10:0] frame;
    frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
        ps2_data = frame[i];
        idle_cycles(PS2_HALF_BIT);
        ps2_clk = 1'b0;
        idle_cycles(PS2_HALF_BIT);
        ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    idle_cycles(2 * PS2_HALF_BIT);
endtask

task automatic wait_irq(input logic level, input int limit);
    int n;
    n = 0;
    while (kbd_irq !== level && n < limit) begin
        idle_cycles(1);
        n++;
    end
    if (kbd_irq !== level) begin
        error_count++;
        $display("Timeout: keyboard interrupt never reached %b in %0d cycles", level, limit);
    end
endtask

task automatic wait_digit(input int digit, input int limit);
    int n;
    n = 0;
    while (dsp_anode !== ~(8'h01 << digit) && n < limit) begin
        idle_cycles(1);
        n++;
    end
    if (dsp_anode !== ~(8'h01 << digit)) begin
        error_count++;
        $display("Timeout: display never selected digit %0d in %0d cycles", digit, limit);
    end
endtask

initial begin
    logic [WORD_W-1:0] rdata;
    logic [WORD_W-1:0] rnd;
    logic [WORD_W-1:0] data;
    logic [WORD_W-1:0] dsp_value;
    logic [9:0]        idx;
    logic [9:0]        idx_list [8];
    logic [7:0]        code;
    logic [7:0]        key_codes [4];
    logic [3:0]        key_release;

    seed        = 32'h066f_7586;
    check_count = 0;
    error_count = 0;
    test_start  = 0;
    reset_async = 1'b1;
    ps2_clk     = 1'b1;
    ps2_data    = 1'b1;
    switch_in   = 16'h0000;
    bus_addr    = IDLE_ADDR;
    bus_wdata   = 32'h0;
    bus_mask    = 4'h0;

    repeat (2) @(posedge cpu_clk);
    #2;
    reset_async = 1'b0;
    // Let the reset chain run out
    idle_cycles(16);
    check("reset read data", 32'h0, bus_rdata);
    check("reset irq", 32'h0, {31'h0, kbd_irq});
    check("reset anode", 32'h0000_00FE, {24'h0, dsp_anode});
    end_test("reset");

    for (int i = 0; i < 8; i++) begin
        rnd  = $random(seed);
        data = $random(seed);
        idx_list[i] = rnd[9:0];
        bus_write({REGION_RAM, 16'h0000, rnd[9:0], 2'b00}, data, 4'hF);
        ram_shadow[rnd[9:0]] = data;
    end
    for (int i = 0; i < 24; i++) begin
        rnd  = $random(seed);
        data = $random(seed);
        idx  = idx_list[rnd[2:0]];
        // Upper offset bits alias onto the same word
        bus_write({REGION_RAM, rnd[31:16], idx, 2'b00}, data, rnd[7:4]);
        ram_shadow[idx] = merge_bytes(ram_shadow[idx], data, rnd[7:4]);
        rnd = $random(seed);
        bus_read({REGION_RAM, rnd[31:16], idx, rnd[1:0]}, rdata);
        check("ram masked write", ram_shadow[idx], rdata);
    end
    for (int i = 0; i < 8; i++) begin
        bus_read({REGION_RAM, 16'h0000, idx_list[i], 2'b00}, rdata);
        check("ram readback", ram_shadow[idx_list[i]], rdata);
    end
    // RAM words at the same offsets as the BIOS and VRAM accesses
    bus_write(32'h1000_0100, 32'h0BAD_F00D, 4'hF);
    ram_shadow[10'h040] = 32'h0BAD_F00D;
    bus_write(32'h1000_0040, 32'h5EED_1234, 4'hF);
    ram_shadow[10'h010] = 32'h5EED_1234;
    bus_write(32'h0000_0100, 32'hDEAD_BEEF, 4'hF);
    bus_read(32'h0000_0100, rdata);
    check("bios region", 32'h0, rdata);
    bus_write(32'h2000_0040, 32'hCAFE_F00D, 4'hF);
    bus_read(32'h2000_0040, rdata);
    check("vram region", 32'h0, rdata);
    bus_read(32'h1000_0100, rdata);
    check("ram after bios write", ram_shadow[10'h040], rdata);
    bus_read(32'h1000_0040, rdata);
    check("ram after vram write", ram_shadow[10'h010], rdata);
    end_test("ram");

    for (int i = 0; i < 2; i++) begin
        rnd = $random(seed);
        switch_in = rnd[15:0];
        repeat (3) @(posedge cpu_clk);
        bus_read(ADDR_SWITCH, rdata);
        check("switch word", {16'h0000, rnd[15:0]}, rdata);
    end
    bus_read(32'hFF00_000C, rdata);
    check("unmapped io", 32'h0, rdata);
    bus_read(32'hFF00_1000, rdata);
    check("unmapped io", 32'h0, rdata);
    bus_read(32'h3000_0000, rdata);
    check("unmapped region", 32'h0, rdata);
    end_test("switch");

    bus_read(ADDR_DISPLAY, rdata);
    check("display reset", 32'h0, rdata);
    dsp_value = merge_bytes(32'h0, 32'h1234_5678, 4'hF);
    bus_write(ADDR_DISPLAY, 32'h1234_5678, 4'hF);
    dsp_value = merge_bytes(dsp_value, 32'hAB00_00CD, 4'b1001);
    bus_write(ADDR_DISPLAY, 32'hAB00_00CD, 4'b1001);
    bus_write(ADDR_DISPLAY, 32'hFFFF_FFFF, 4'h0);
    bus_read(ADDR_DISPLAY, rdata);
    check("display register", dsp_value, rdata);
    for (int d = 0; d < 8; d++) begin
        wait_digit(d, DIGIT_LIMIT);
        check("display cathode", {24'h0, seg_pattern(dsp_value[d*4 +: 4])},
              {24'h0, dsp_cathode});
    end
    end_test("display");

    key_codes   = '{8'h1C, 8'h32, 8'h21, 8'h1C};
    key_release = 4'b1000;
    check("irq before keys", 32'h0, {31'h0, kbd_irq});
    send_ps2_frame(8'h1C, 1'b0);
    wait_irq(1'b1, 50);
    send_ps2_frame(8'h32, 1'b0);
    send_ps2_frame(8'h21, 1'b0);
    send_ps2_frame(PS2_BREAK_CODE, 1'b0);
    send_ps2_frame(8'h1C, 1'b0);
    idle_cycles(10);
    for (int i = 0; i < 4; i++) begin
        bus_read(ADDR_KBD, rdata);
        check("key event", kbd_word(1'b1, key_release[i], key_codes[i]), rdata);
    end
    bus_read(ADDR_KBD, rdata);
    check("key queue empty", kbd_word(1'b0, 1'b0, 8'h00), rdata);
    check("irq after reads", 32'h0, {31'h0, kbd_irq});
    end_test("keyboard");

    send_ps2_frame(8'h1C, 1'b1);
    idle_cycles(20);
    check("bad parity irq", 32'h0, {31'h0, kbd_irq});
    bus_read(ADDR_KBD, rdata);
    check("bad parity read", kbd_word(1'b0, 1'b0, 8'h00), rdata);
    for (int i = 0; i < 18; i++) begin
        send_ps2_frame(8'h40 + 8'(i), 1'b0);
    end
    idle_cycles(10);
    check("overflow irq", 32'h1, {31'h0, kbd_irq});
    for (int i = 0; i < KBD_FIFO_DEPTH; i++) begin
        code = 8'h40 + 8'(i);
        bus_read(ADDR_KBD, rdata);
        check("overflow event", kbd_word(1'b1, 1'b0, code), rdata);
    end
    bus_read(ADDR_KBD, rdata);
    check("overflow dropped", kbd_word(1'b0, 1'b0, 8'h00), rdata);
    check("overflow irq clear", 32'h0, {31'h0, kbd_irq});
    end_test("overflow");

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
        $display("TB PASSED");
    end else begin
        $display("TB FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: kbd_controller.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_controller
    import soc_pkg::*;
    (
        input  wire logic             cpu_clk_i,
        input  wire logic             reset_i,
        input  wire logic             ps2_clk_async_i,
        input  wire logic             ps2_data_async_i,
        input  wire logic             read_enable_i,
        output logic [KBD_EVENT_W-1:0] read_data_o,
        output logic                  read_valid_o,
        output logic                  irq_o
    );

logic [7:0]             rx_byte_w;
logic                   rx_valid_w;

logic                   release_r;
logic [KBD_EVENT_W-1:0] fifo_mem_r [KBD_FIFO_DEPTH];
logic [KBD_FIFO_AW-1:0] wr_ptr_r;
logic [KBD_FIFO_AW-1:0] rd_ptr_r;
logic [KBD_COUNT_W-1:0] count_r;

logic                   is_break_w;
logic                   fifo_empty_w;
logic                   fifo_full_w;
logic                   push_w;
logic                   pop_w;

ps2_receiver i_rx (
    .cpu_clk_i        (cpu_clk_i),
    .reset_i          (reset_i),
    .ps2_clk_async_i  (ps2_clk_async_i),
    .ps2_data_async_i (ps2_data_async_i),
    .byte_o           (rx_byte_w),
    .byte_valid_o     (rx_valid_w)
);

assign is_break_w   = (rx_byte_w == PS2_BREAK_CODE);
assign fifo_empty_w = (count_r == '0);
assign fifo_full_w  = (count_r == KBD_COUNT_W'(KBD_FIFO_DEPTH));

// Newest event is dropped when full
assign push_w = rx_valid_w & ~is_break_w & ~fifo_full_w;
assign pop_w  = read_enable_i & ~fifo_empty_w;
assign irq_o  = ~fifo_empty_w;

// Break prefix marks the next code as a release
always_ff @(posedge cpu_clk_i) begin
    if (reset_i) begin
        release_r <= 1'b0;
    end else if (rx_valid_w) begin
        release_r <= is_break_w;
    end
end

always_ff @(posedge cpu_clk_i) begin
    if (push_w) begin
        fifo_mem_r[wr_ptr_r] <= {release_r, rx_byte_w};
    end
end

always_ff @(posedge cpu_clk_i) begin
    if (reset_i) begin
        wr_ptr_r     <= '0;
        rd_ptr_r     <= '0;
        count_r      <= '0;
        read_data_o  <= '0;
        read_valid_o <= 1'b0;
    end else begin
        if (push_w) begin
            wr_ptr_r <= wr_ptr_r + 1'b1;
        end
        if (pop_w) begin
            rd_ptr_r <= rd_ptr_r + 1'b1;
        end
        if (push_w && !pop_w) begin
            count_r <= count_r + 1'b1;
        end else if (pop_w && !push_w) begin
            count_r <= count_r - 1'b1;
        end
        // Each bus read cycle takes the head, or zero when empty
        if (read_enable_i) begin
            read_data_o  <= fifo_empty_w ? '0 : fifo_mem_r[rd_ptr_r];
            read_valid_o <= ~fifo_empty_w;
        end
    end
end

a_count_bounded: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
    count_r <= KBD_COUNT_W'(KBD_FIFO_DEPTH));

endmodule

`default_nettype wire

// File: ps2_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver
    import soc_pkg::*;
    (
        input  wire logic       cpu_clk_i,
        input  wire logic       reset_i,
        input  wire logic       ps2_clk_async_i,
        input  wire logic       ps2_data_async_i,
        output logic [7:0]      byte_o,
        output logic            byte_valid_o
    );

// Clock line: [0] first flop, [1] synchronized, [2] previous sample
logic [2:0]                clk_sync_r;
logic [1:0]                data_sync_r;
logic                      clk_fall_w;

logic [PS2_FRAME_BITS-1:0] shift_r;
logic [PS2_BIT_CNT_W-1:0]  bit_cnt_r;
logic [PS2_IDLE_W-1:0]     idle_cnt_r;
logic                      frame_done_r;
logic                      frame_ok_r;

always_ff @(posedge cpu_clk_i) begin
    if (reset_i) begin
        // Idle PS/2 clock is high, so no false edge out of reset
        clk_sync_r <= '1;
    end else begin
        clk_sync_r <= {clk_sync_r[1:0], ps2_clk_async_i};
    end
end

always_ff @(posedge cpu_clk_i) begin
    data_sync_r <= {data_sync_r[0], ps2_data_async_i};
end

assign clk_fall_w = clk_sync_r[2] & ~clk_sync_r[1];

// Frame bits arrive LSB first, start bit ends up in bit 0
always_ff @(posedge cpu_clk_i) begin
    if (clk_fall_w) begin
        shift_r <= {data_sync_r[1], shift_r[PS2_FRAME_BITS-1:1]};
    end
end

// Bit counter with idle timeout on a partial frame
always_ff @(posedge cpu_clk_i) begin
    if (reset_i) begin
        bit_cnt_r    <= '0;
        idle_cnt_r   <= '0;
        frame_done_r <= 1'b0;
    end else begin
        frame_done_r <= 1'b0;
        if (clk_fall_w) begin
            idle_cnt_r <= '0;
            if (bit_cnt_r == PS2_BIT_CNT_W'(PS2_FRAME_BITS - 1)) begin
                bit_cnt_r    <= '0;
                frame_done_r <= 1'b1;
            end else begin
                bit_cnt_r <= bit_cnt_r + 1'b1;
            end
        end else if (bit_cnt_r != '0) begin
            if (idle_cnt_r == PS2_IDLE_W'(PS2_IDLE_CYCLES - 1)) begin
                // Device stopped clocking mid-frame
                bit_cnt_r  <= '0;
                idle_cnt_r <= '0;
            end else begin
                idle_cnt_r <= idle_cnt_r + 1'b1;
            end
        end
    end
end

// Start low, stop high, odd parity over data and parity bit
always_ff @(posedge cpu_clk_i) begin
    if (reset_i) begin
        frame_ok_r   <= 1'b0;
        byte_valid_o <= 1'b0;
    end else begin
        frame_ok_r   <= frame_done_r & ~shift_r[0] & shift_r[10] & (^shift_r[9:1]);
        byte_valid_o <= frame_ok_r;
    end
end

always_ff @(posedge cpu_clk_i) begin
    if (frame_done_r) begin
        byte_o <= shift_r[8:1];
    end
end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the chipset testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module chipset_tb -f chipset.f -o chipset_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/chipset_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: seg_display.sv
`timescale 1ns/1ps
`default_nettype none

module seg_display
    import soc_pkg::*;
    (
        input  wire logic                  cpu_clk_i,
        input  wire logic                  reset_i,
        input  wire logic [WORD_W-1:0]     write_data_i,
        input  wire logic [WORD_BYTES-1:0] write_mask_i,
        output logic [WORD_W-1:0]          read_data_o,
        output logic [7:0]                 dsp_anode_o,
        output logic [7:0]                 dsp_cathode_o
    );

logic [WORD_W-1:0]    value_r;
logic [SEG_DIV_W-1:0] div_cnt_r;
logic [2:0]           digit_r;
logic [3:0]           nibble_w;

// Active-low segments, bit 6 is g down to bit 0 is a
function automatic logic [6:0] hex_segments(input logic [3:0] nibble);
    logic [6:0] seg;
    case (nibble)
        4'h0:    seg = 7'b100_0000;
        4'h1:    seg = 7'b111_1001;
        4'h2:    seg = 7'b010_0100;
        4'h3:    seg = 7'b011_0000;
        4'h4:    seg = 7'b001_1001;
        4'h5:    seg = 7'b001_0010;
        4'h6:    seg = 7'b000_0010;
        4'h7:    seg = 7'b111_1000;
        4'h8:    seg = 7'b000_0000;
        4'h9:    seg = 7'b001_0000;
        4'hA:    seg = 7'b000_1000;
        4'hB:    seg = 7'b000_0011;
        4'hC:    seg = 7'b100_0110;
        4'hD:    seg = 7'b010_0001;
        4'hE:    seg = 7'b000_0110;
        default: seg = 7'b000_1110;
    endcase
    return seg;
endfunction

always_ff @(posedge cpu_clk_i) begin
    if (reset_i) begin
        value_r <= '0;
    end else begin
        for (int i = 0; i < WORD_BYTES; i++) begin
            if (write_mask_i[i]) begin
                value_r[i*8 +: 8] <= write_data_i[i*8 +: 8];
            end
        end
    end
end

assign read_data_o = value_r;

// Scan divider, one digit per SEG_SCAN_DIV cycles
always_ff @(posedge cpu_clk_i) begin
    if (reset_i) begin
        div_cnt_r <= '0;
        digit_r   <= '0;
    end else if (div_cnt_r == SEG_DIV_W'(SEG_SCAN_DIV - 1)) begin
        div_cnt_r <= '0;
        digit_r   <= digit_r + 1'b1;
    end else begin
        div_cnt_r <= div_cnt_r + 1'b1;
    end
end

assign nibble_w      = value_r[{digit_r, 2'b00} +: 4];
assign dsp_anode_o   = ~(8'b0000_0001 << digit_r);
// Decimal point stays dark
assign dsp_cathode_o = {1'b1, hex_segments(nibble_w)};

a_one_anode: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
    $onehot(~dsp_anode_o));

endmodule

`default_nettype wire

// File: soc_pkg.sv
`default_nettype none

package soc_pkg;

    // Bus geometry
    localparam int WORD_W     = 32;
    localparam int WORD_BYTES = WORD_W / 8;

    // Internal reset stretch on cpu_clk_i
    localparam int RESET_CYCLES = 12;

    // Memory map, top nibble selects the region
    localparam logic [3:0] REGION_BIOS = 4'h0;
    localparam logic [3:0] REGION_RAM  = 4'h1;
    localparam logic [3:0] REGION_VRAM = 4'h2;

    localparam logic [WORD_W-1:0] ADDR_DISPLAY = 32'hFF00_0000;
    localparam logic [WORD_W-1:0] ADDR_SWITCH  = 32'hFF00_0004;
    localparam logic [WORD_W-1:0] ADDR_KBD     = 32'hFF00_0008;

    // RAM, word index from offset bits 11:2
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    // Keyboard event FIFO
    localparam int KBD_EVENT_W    = 9;
    localparam int KBD_FIFO_DEPTH = 16;
    localparam int KBD_FIFO_AW    = $clog2(KBD_FIFO_DEPTH);
    localparam int KBD_COUNT_W    = KBD_FIFO_AW + 1;

    // PS/2 framing
    localparam logic [7:0] PS2_BREAK_CODE  = 8'hF0;
    localparam int         PS2_FRAME_BITS  = 11;
    localparam int         PS2_BIT_CNT_W   = $clog2(PS2_FRAME_BITS);
    localparam int         PS2_IDLE_CYCLES = 4096;
    localparam int         PS2_IDLE_W      = $clog2(PS2_IDLE_CYCLES);

    // Display scan rate
    localparam int SEG_SCAN_DIV = 1000;
    localparam int SEG_DIV_W    = $clog2(SEG_SCAN_DIV);

    // Bus address seen as one word or as region plus offset
    typedef union packed {
        logic [WORD_W-1:0] word;
        struct packed {
            logic [3:0]  region;
            logic [27:0] offset;
        } field;
    } bus_addr_u;

endpackage

`default_nettype wire

// File: system_ram.sv
`timescale 1ns/1ps
`default_nettype none

module system_ram
    import soc_pkg::*;
    (
        input  wire logic                  cpu_clk_i,
        input  wire bus_addr_u             addr_i,
        input  wire logic [WORD_W-1:0]     write_data_i,
        input  wire logic [WORD_BYTES-1:0] write_mask_i,
        output logic [WORD_W-1:0]          read_data_o
    );

logic [WORD_W-1:0] mem_r [RAM_WORDS];
logic [RAM_AW-1:0] index_w;

// Byte offset dropped, offset bits above the index alias
assign index_w = addr_i.field.offset[RAM_AW+1:2];

always_ff @(posedge cpu_clk_i) begin
    for (int i = 0; i < WORD_BYTES; i++) begin
        if (write_mask_i[i]) begin
            mem_r[index_w][i*8 +: 8] <= write_data_i[i*8 +: 8];
        end
    end
    // Same-cycle write is not visible until the next read
    read_data_o <= mem_r[index_w];
end

endmodule

`default_nettype wire
